// File: verilog/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth     = 16;
    localparam int regCount      = 16;
    localparam int regIndexWidth = 4;
    localparam int psrWidth      = 5;

    // Status register bit positions
    localparam int flagCarry    = 0;  // Carry or no-borrow
    localparam int flagLower    = 1;  // Source unsigned below dest
    localparam int flagOverflow = 2;  // Signed add overflow
    localparam int flagZero     = 3;  // Operands equal
    localparam int flagNegative = 4;  // Source signed below dest

    // Major nibble followed by extension nibble
    localparam int aluOpWidth = 8;

    localparam logic [aluOpWidth-1:0] opAnd       = 8'b0000_0001;
    localparam logic [aluOpWidth-1:0] opOr        = 8'b0000_0010;
    localparam logic [aluOpWidth-1:0] opXor       = 8'b0000_0011;
    localparam logic [aluOpWidth-1:0] opAdd       = 8'b0000_0101;
    localparam logic [aluOpWidth-1:0] opAddu      = 8'b0000_0110;
    localparam logic [aluOpWidth-1:0] opSub       = 8'b0000_1001;
    localparam logic [aluOpWidth-1:0] opCmp       = 8'b0000_1011;
    localparam logic [aluOpWidth-1:0] opMov       = 8'b0000_1101;
    localparam logic [aluOpWidth-1:0] opLsh       = 8'b1000_0100;
    localparam logic [aluOpWidth-1:0] opLshiLeft  = 8'b1000_0000;
    localparam logic [aluOpWidth-1:0] opLshiRight = 8'b1000_0001;
    // LUI carries its immediate in the extension nibble, decoder folds it to zero
    localparam logic [aluOpWidth-1:0] opLui       = 8'b1111_0000;

    localparam logic [3:0] majorLui = 4'b1111;

endpackage

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [cpuPkg::regIndexWidth-1:0]    readIndexA,
    input  logic [cpuPkg::regIndexWidth-1:0]    readIndexB,
    input  logic [cpuPkg::regIndexWidth-1:0]    writeIndex,
    input  logic [cpuPkg::dataWidth-1:0]        writeData,
    input  logic                                writeEnable,
    output logic [cpuPkg::dataWidth-1:0]        readDataA,
    output logic [cpuPkg::dataWidth-1:0]        readDataB
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    // Pending write wins over the stored value
    always_comb begin
        if (writeEnable && (writeIndex == readIndexA)) begin
            readDataA = writeData;
        end else begin
            readDataA = regs[readIndexA];
        end
    end

    always_comb begin
        if (writeEnable && (writeIndex == readIndexB)) begin
            readDataB = writeData;
        end else begin
            readDataB = regs[readIndexB];
        end
    end

endmodule

// File: verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic [cpuPkg::dataWidth-1:0]        instr,
    input  logic                                instrValid,
    output logic [cpuPkg::regIndexWidth-1:0]    destIndex,
    output logic [cpuPkg::regIndexWidth-1:0]    srcIndex,
    output logic [7:0]                          imm,
    output logic [cpuPkg::aluOpWidth-1:0]       aluOp,
    output logic                                writeBack,
    output logic                                execValid
);
    import cpuPkg::*;

    logic [3:0] major;
    logic [3:0] extension;
    logic       knownOp;

    assign major     = instr[15:12];
    assign extension = instr[7:4];

    assign destIndex = instr[11:8];
    assign srcIndex  = instr[3:0];  // Also the shift amount for LSHI
    assign imm       = instr[7:0];

    // LUI has no extension nibble
    always_comb begin
        if (major == majorLui) begin
            aluOp = opLui;
        end else begin
            aluOp = {major, extension};
        end
    end

    always_comb begin
        case (aluOp)
            opAnd,
            opOr,
            opXor,
            opAdd,
            opAddu,
            opSub,
            opCmp,
            opMov,
            opLsh,
            opLshiLeft,
            opLshiRight,
            opLui:   knownOp = 1'b1;
            default: knownOp = 1'b0;
        endcase
    end

    assign writeBack = (aluOp != opCmp);  // CMP only touches flags
    assign execValid = instrValid & knownOp;

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [cpuPkg::aluOpWidth-1:0]       aluOp,
    input  logic [cpuPkg::dataWidth-1:0]        operandA,
    input  logic [cpuPkg::dataWidth-1:0]        operandB,
    input  logic [7:0]                          imm,
    input  logic [cpuPkg::regIndexWidth-1:0]    destIndex,
    input  logic                                writeBack,
    input  logic                                execValid,
    output logic [cpuPkg::dataWidth-1:0]        result,
    output logic [cpuPkg::psrWidth-1:0]         psr,
    output logic                                resultValid,
    output logic [cpuPkg::regIndexWidth-1:0]    writeIndex,
    output logic                                writeEnable
);
    import cpuPkg::*;

    logic [dataWidth:0]   sum;
    logic [dataWidth:0]   diff;
    logic [7:0]           shiftCount;
    logic [7:0]           shiftMag;
    logic [dataWidth-1:0] lshValue;
    logic                 addOverflow;
    logic [dataWidth-1:0] nextResult;
    logic [psrWidth-1:0]  nextPsr;

    assign sum  = {1'b0, operandA} + {1'b0, operandB};
    assign diff = {1'b0, operandA} - {1'b0, operandB};  // Top bit is the borrow

    // Both operands share a sign and the sum flips it
    assign addOverflow = (operandA[dataWidth-1] == operandB[dataWidth-1]) &&
                         (sum[dataWidth-1] != operandA[dataWidth-1]);

    // Signed count from the source low byte
    assign shiftCount = operandB[7:0];
    assign shiftMag   = -shiftCount;  // Magnitude when negative
    always_comb begin
        if (shiftCount[7]) begin
            lshValue = operandA >> shiftMag;
        end else begin
            lshValue = operandA << shiftCount;
        end
    end

    always_comb begin
        nextResult = '0;
        nextPsr    = psr;  // Untouched flags hold
        case (aluOp)
            opAnd:  nextResult = operandA & operandB;
            opOr:   nextResult = operandA | operandB;
            opXor:  nextResult = operandA ^ operandB;
            opAdd: begin
                nextResult             = sum[dataWidth-1:0];
                nextPsr[flagCarry]    = sum[dataWidth];
                nextPsr[flagOverflow] = addOverflow;
            end
            opAddu: begin
                nextResult          = sum[dataWidth-1:0];
                nextPsr[flagCarry] = sum[dataWidth];
            end
            opSub: begin
                nextResult          = diff[dataWidth-1:0];
                nextPsr[flagCarry] = ~diff[dataWidth];
            end
            opCmp: begin
                nextPsr[flagZero]     = (operandA == operandB);
                nextPsr[flagLower]    = (operandB < operandA);
                nextPsr[flagNegative] = ($signed(operandB) < $signed(operandA));
            end
            opMov:       nextResult = operandB;
            opLsh:       nextResult = lshValue;
            opLshiLeft:  nextResult = operandA << imm[3:0];
            opLshiRight: nextResult = operandA >> imm[3:0];
            opLui:       nextResult = {imm, 8'h00};
            default:     nextResult = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            result      <= '0;
            psr         <= '0;
            resultValid <= 1'b0;
            writeIndex  <= '0;
            writeEnable <= 1'b0;
        end else begin
            resultValid <= execValid;
            writeEnable <= execValid & writeBack;
            writeIndex  <= destIndex;
            if (execValid) begin
                result <= nextResult;
                psr    <= nextPsr;
            end else begin
                result <= '0;  // Idle or dropped instruction
            end
        end
    end

endmodule

// File: verilog/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [cpuPkg::dataWidth-1:0]        instr,
    input  logic                                instrValid,
    output logic [cpuPkg::dataWidth-1:0]        result,
    output logic [cpuPkg::psrWidth-1:0]         psr,
    output logic                                resultValid,
    output logic [cpuPkg::regIndexWidth-1:0]    writeIndex,
    output logic                                writeEnable
);
    import cpuPkg::*;

    logic [regIndexWidth-1:0] destIndex;
    logic [regIndexWidth-1:0] srcIndex;
    logic [7:0]               imm;
    logic [aluOpWidth-1:0]    aluOp;
    logic                     writeBack;
    logic                     execValid;
    logic [dataWidth-1:0]     destData;
    logic [dataWidth-1:0]     srcData;

    instrDecode decode_i (
        .instr      (instr),
        .instrValid (instrValid),
        .destIndex  (destIndex),
        .srcIndex   (srcIndex),
        .imm        (imm),
        .aluOp      (aluOp),
        .writeBack  (writeBack),
        .execValid  (execValid)
    );

    // Write port fed straight from the ALU register
    regFile regs_i (
        .clock       (clock),
        .reset       (reset),
        .readIndexA  (destIndex),
        .readIndexB  (srcIndex),
        .writeIndex  (writeIndex),
        .writeData   (result),
        .writeEnable (writeEnable),
        .readDataA   (destData),
        .readDataB   (srcData)
    );

    alu alu_i (
        .clock       (clock),
        .reset       (reset),
        .aluOp       (aluOp),
        .operandA    (destData),
        .operandB    (srcData),
        .imm         (imm),
        .destIndex   (destIndex),
        .writeBack   (writeBack),
        .execValid   (execValid),
        .result      (result),
        .psr         (psr),
        .resultValid (resultValid),
        .writeIndex  (writeIndex),
        .writeEnable (writeEnable)
    );

endmodule

// File: dv/resultChecker.sv
`timescale 1ns/1ps

module resultChecker (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [cpuPkg::dataWidth-1:0]    result,
    input  logic [cpuPkg::psrWidth-1:0]     psr,
    input  logic                            resultValid,
    input  logic [cpuPkg::regIndexWidth-1:0] writeIndex,
    input  logic                            writeEnable,
    input  logic                            endOfRun,
    output logic                            allSeen,
    output int                              valueErrors,
    output int                              missingResults,
    output int                              extraResults
);
    import cpuPkg::*;

    localparam string caseFile = "dv/execCore_cases.txt";

    logic [dataWidth-1:0]     expResult [$];
    logic [psrWidth-1:0]      expPsr [$];
    logic [regIndexWidth-1:0] expIndex [$];
    logic                     expWrite [$];
    int                       expectedTotal;
    int                       seen;
    bit                       reported;

    task automatic loadExpected();
        int          fd;
        string       line;
        logic [31:0] word;
        logic [31:0] res;
        logic [31:0] flags;
        logic [31:0] mode;
        fd = $fopen(caseFile, "r");
        if (fd == 0) begin
            $display("Checker could not open the case file %s", caseFile);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%h %h %h %h", word, res, flags, mode) == 4) begin
                    if (!mode[1]) begin  // Undefined opcodes give no strobe
                        expResult.push_back(res[dataWidth-1:0]);
                        expPsr.push_back(flags[psrWidth-1:0]);
                        expIndex.push_back(word[11:8]);
                        // CMP writes nothing back
                        expWrite.push_back(!((word[15:12] == 4'h0) && (word[7:4] == 4'hB)));
                    end
                end
            end
            $fclose(fd);
        end
        expectedTotal = expResult.size();
    endtask

    initial begin
        valueErrors    = 0;
        missingResults = 0;
        extraResults   = 0;
        seen           = 0;
        reported       = 1'b0;
        allSeen        = 1'b0;
        loadExpected();
        forever begin
            @(negedge clock);  // Registered outputs are settled here
            if (reset && resultValid) begin
                if (seen >= expectedTotal) begin
                    extraResults++;
                    $display("%0t: a result strobe arrived after all %0d expected results",
                             $time, expectedTotal);
                end else begin
                    if (result !== expResult[seen]) begin
                        valueErrors++;
                        $display("ERR %0t: case %0d result is %h, expected %h",
                                 $time, seen, result, expResult[seen]);
                    end
                    if (psr !== expPsr[seen]) begin
                        valueErrors++;
                        $display("ERR %0t: case %0d psr is %h, expected %h",
                                 $time, seen, psr, expPsr[seen]);
                    end
                    if (writeEnable !== expWrite[seen]) begin
                        valueErrors++;
                        $display("ERR %0t: case %0d writeEnable is %b, expected %b",
                                 $time, seen, writeEnable, expWrite[seen]);
                    end
                    if (expWrite[seen] && writeIndex !== expIndex[seen]) begin
                        valueErrors++;
                        $display("ERR %0t: case %0d writeIndex is %h, expected %h",
                                 $time, seen, writeIndex, expIndex[seen]);
                    end
                    seen++;
                end
            end else if (reset && writeEnable) begin
                valueErrors++;
                $display("ERR %0t: writeEnable is high without a result strobe", $time);
            end
            allSeen = (seen >= expectedTotal);
            if (endOfRun && !reported) begin
                reported = 1'b1;
                if (seen < expectedTotal) begin
                    missingResults = expectedTotal - seen;
                    $display("Only %0d of %0d expected results arrived", seen, expectedTotal);
                end
            end
        end
    end

endmodule

// File: dv/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;
    import cpuPkg::*;

    localparam string caseFile    = "dv/execCore_cases.txt";
    localparam int    seed        = 84916;
    localparam int    resetCycles = 16;

    logic                     clock = 1'b0;
    logic                     reset;
    logic [dataWidth-1:0]     instr;
    logic                     instrValid;
    logic [dataWidth-1:0]     result;
    logic [psrWidth-1:0]      psr;
    logic                     resultValid;
    logic [regIndexWidth-1:0] writeIndex;
    logic                     writeEnable;

    logic endOfRun;
    logic allSeen;
    int   valueErrors;
    int   missingResults;
    int   extraResults;

    logic [dataWidth-1:0] caseInstr [$];
    logic [3:0]           caseMode [$];  // Bit 0 set means no idle gap after
    int                   cycleCount = 0;
    int                   timeoutLimit;
    int                   fileErrors;
    int                   totalErrors;
    bit                   timedOut;

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    execCore dut_i (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .result      (result),
        .psr         (psr),
        .resultValid (resultValid),
        .writeIndex  (writeIndex),
        .writeEnable (writeEnable)
    );

    resultChecker checker_i (
        .clock          (clock),
        .reset          (reset),
        .result         (result),
        .psr            (psr),
        .resultValid    (resultValid),
        .writeIndex     (writeIndex),
        .writeEnable    (writeEnable),
        .endOfRun       (endOfRun),
        .allSeen        (allSeen),
        .valueErrors    (valueErrors),
        .missingResults (missingResults),
        .extraResults   (extraResults)
    );

    task automatic loadCases();
        int          fd;
        string       line;
        logic [31:0] word;
        logic [31:0] expResult;
        logic [31:0] expFlags;
        logic [31:0] mode;
        fd = $fopen(caseFile, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", caseFile);
            fileErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 &&
                    $sscanf(line, "%h %h %h %h", word, expResult, expFlags, mode) == 4) begin
                    caseInstr.push_back(word[dataWidth-1:0]);
                    caseMode.push_back(mode[3:0]);
                end
            end
            $fclose(fd);
            if (caseInstr.size() == 0) begin
                $display("The case file %s holds no cases", caseFile);
                fileErrors++;
            end
        end
    endtask

    initial begin
        int gap;
        void'($urandom(seed));
        reset      <= 1'b0;
        instr      <= '0;
        instrValid <= 1'b0;
        endOfRun   <= 1'b0;
        timedOut    = 1'b0;
        fileErrors  = 0;
        loadCases();
        timeoutLimit = caseInstr.size() * 5 + 50;

        repeat (resetCycles) @(posedge clock);
        reset <= 1'b1;

        for (int i = 0; i < caseInstr.size(); i++) begin
            @(posedge clock);
            instr      <= caseInstr[i];
            instrValid <= 1'b1;
            if (!caseMode[i][0]) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clock);
                    instr      <= '0;
                    instrValid <= 1'b0;
                end
            end
        end
        @(posedge clock);
        instr      <= '0;
        instrValid <= 1'b0;

        while (!allSeen && !timedOut) begin
            @(posedge clock);
            if (cycleCount >= timeoutLimit) begin
                timedOut = 1'b1;
                $display("Timeout after %0d cycles while waiting for results", cycleCount);
            end
        end

        repeat (4) @(posedge clock);  // Room for a stray strobe
        endOfRun <= 1'b1;
        repeat (2) @(posedge clock);

        totalErrors = valueErrors + missingResults + extraResults + fileErrors;
        if (timedOut) begin
            totalErrors++;
        end
        $display("Errors: value %0d, missing %0d, extra %0d, file %0d, timeout %0d",
                 valueErrors, missingResults, extraResults, fileErrors, timedOut);
        if (totalErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/execCore_cases.txt
// instr  result  flags  mode, all hex
// mode bit 0 means the next instruction follows with no idle gap, bit 1 means no result strobe
F112 1200 00 0
F234 3400 00 0
F380 8000 00 0
F47F 7F00 00 0
F5FF FF00 00 0
06D1 1200 00 0
07D5 FF00 00 0
F80F 0F00 00 0
8818 000F 00 0
F956 5600 00 0
8914 0560 00 0
0928 056F 00 0
0129 176F 00 0
0AD1 176F 00 0
0A17 1700 00 0
0A39 126F 00 0
0A23 926F 00 0
0261 4B6F 00 0
0765 FE00 01 0
0454 FE00 04 0
0355 7F00 05 0
0859 057E 00 0
0998 FFF1 00 0
0196 056F 01 0
0B67 FE00 00 0
04B7 0000 08 0
02B1 0000 12 0
01B9 0000 10 0
09B1 0000 02 0
0CD9 FFF1 02 0
0CD2 4B6F 02 0
FD04 0400 02 0
8D18 0004 02 0
0ED1 056F 02 0
8E4D 56F0 02 0
FFFD FD00 02 0
8F18 00FD 02 0
8E4F 0ADE 02 0
8E0C E000 02 0
8E1D 0007 02 0
8A49 0001 02 0
8548 0000 02 0
00D3 7F00 02 1
0050 FE00 06 1
0072 0000 06 3
0064 FC00 07 1
0490 0200 07 1
04B0 0000 15 1
01D4 0200 15 1
8125 0000 15 3
0131 0000 15 0
02D0 FC00 15 0

// File: flist.f
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/instrDecode.sv
verilog/alu.sv
verilog/execCore.sv
dv/resultChecker.sv
dv/execCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

verilator --binary --top-module execCoreTb -f flist.f \
    --Mdir "$buildDir" -o simExecCore > "$buildLog" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$buildLog"
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$buildDir/simExecCore" > "$simLog" 2>&1
status=$?
cat "$simLog"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "SOME TESTS FAILED" "$simLog"
found=$?
if [ $found -eq 0 ]; then
    echo "Run failed, see $simLog"
    exit 1
fi
if [ $found -ne 1 ]; then
    echo "Could not search $simLog"
    exit 1
fi

echo "Run passed"
exit 0
